// File: compile.f
+incdir+rtl
rtl/layer_pkg.sv
rtl/lut_bram.sv
rtl/neuron_sum.sv
rtl/activation.sv
rtl/activation_layer.sv
bench/activation_layer_properties.sv
bench/activation_layer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the activation layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module activation_layer_tb \
    --Mdir obj_dir -o activation_layer_sim

./obj_dir/activation_layer_sim

// File: bench/activation_layer_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "layer_macros.svh"

module activation_layer_tb;

    localparam int LUT_DEPTH      = 1 << `LUT_ADDR_SIZE;
    localparam int PRE_MAX        = (1 << (`LUT_ADDR_SIZE - 1)) - 1;
    localparam int PRE_MIN        = -(1 << (`LUT_ADDR_SIZE - 1));
    localparam int SETTLE_TIMEOUT = 40;
    localparam int LOW_LIMIT      = 3;    // samples allowed before stable must drop
    localparam int NUM_VECTORS    = 200;

    localparam logic [7:0] LOW_END_DATA  = 8'h5a;  // LUT entry 0
    localparam logic [7:0] HIGH_END_DATA = 8'ha5;  // last LUT entry

    logic                               clk = 1'b0;
    logic                               rst;
    logic [`NUM_INPUTS*`IN_WIDTH-1:0]   x;
    logic                               cfg_we;
    layer_pkg::cfg_addr_t               cfg_addr;
    logic [7:0]                         cfg_data;
    logic [`NUM_NEURON*`LUT_WIDTH-1:0]  outputs;
    logic                               stable;

    // reference model state
    logic [31:0]        lcg_state;
    logic signed [7:0]  w_model [`NUM_NEURON][`NUM_INPUTS];
    logic [7:0]         lut_model [LUT_DEPTH];
    int                 last_addr [`NUM_NEURON];  // addresses the DUT currently holds

    activation_layer dut_i (
        .clk      (clk),
        .rst      (rst),
        .x        (x),
        .cfg_we   (cfg_we),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .outputs  (outputs),
        .stable   (stable)
    );

    bind activation activation_layer_properties props_i (
        .clk    (clk),
        .rst    (rst),
        .preact (preact),
        .stable (stable),
        .count  (count)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = next_rand();
        return r[23:16]; // upper bits, the low ones cycle fast
    endfunction

    // dot product, shift, clamp, then offset into the LUT range
    function automatic int model_addr(input int n, input logic [`NUM_INPUTS*`IN_WIDTH-1:0] xv);
        int acc;
        int xi;
        acc = 0;
        for (int i = 0; i < `NUM_INPUTS; i++) begin
            xi = int'($signed(xv[i*`IN_WIDTH +: `IN_WIDTH]));
            acc = acc + xi * int'(w_model[n][i]);
        end
        acc = acc >>> `SUM_SHIFT;
        if (acc > PRE_MAX) begin
            acc = PRE_MAX;
        end else if (acc < PRE_MIN) begin
            acc = PRE_MIN;
        end
        return acc - PRE_MIN;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic write_lut(input int addr, input logic [7:0] data);
        layer_pkg::cfg_addr_t a;
        a = '0;
        a.lut.sel = 1'b1;
        a.lut.lut_addr = addr[`LUT_ADDR_SIZE-1:0];
        @(posedge clk);
        cfg_we   <= 1'b1;
        cfg_addr <= a;
        cfg_data <= data;
        lut_model[addr] = data;
    endtask

    task automatic write_weight(input int neuron, input int inp, input logic [7:0] data);
        layer_pkg::cfg_addr_t a;
        a = '0;
        a.weight.sel = 1'b0;
        a.weight.neuron = neuron[`NEURON_IDX_SIZE-1:0];
        a.weight.input_idx = inp[`INPUT_IDX_SIZE-1:0];
        @(posedge clk);
        cfg_we   <= 1'b1;
        cfg_addr <= a;
        cfg_data <= data;
        if (neuron < `NUM_NEURON) begin
            w_model[neuron][inp] = data; // indices 6 and 7 go nowhere
        end
    endtask

    task automatic end_cfg();
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic wait_stable_high();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!stable) begin
            cycles++;
            if (cycles >= SETTLE_TIMEOUT) begin
                $display("stable did not rise within %0d cycles at %0t", SETTLE_TIMEOUT, $time);
                $display("ERRORS FOUND");
                $fatal(1, "settle timeout");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_stable_low();
        int samples;
        samples = 1;
        @(negedge clk);
        while (stable) begin
            if (samples >= LOW_LIMIT) begin
                $display("stable stayed high after a pre-activation change at %0t", $time);
                $display("ERRORS FOUND");
                $fatal(1, "stable did not drop");
            end
            samples++;
            @(negedge clk);
        end
    endtask

    // every neuron: address seen by the LUT and the value it returned
    task automatic check_outputs();
        int addr;
        for (int n = 0; n < `NUM_NEURON; n++) begin
            addr = model_addr(n, x);
            check_value($sformatf("preact[%0d]", n),
                        dut_i.preact[n*`LUT_ADDR_SIZE +: `LUT_ADDR_SIZE], addr);
            check_value($sformatf("outputs[%0d]", n),
                        outputs[n*`LUT_WIDTH +: `LUT_WIDTH], lut_model[addr]);
            last_addr[n] = addr;
        end
    endtask

    // even and odd neurons pinned at opposite ends of the LUT
    task automatic check_ends(input int even_addr, input int odd_addr);
        int         addr;
        logic [7:0] data;
        for (int n = 0; n < `NUM_NEURON; n++) begin
            addr = (n % 2 == 0) ? even_addr : odd_addr;
            data = (addr == 0) ? LOW_END_DATA : HIGH_END_DATA;
            check_value($sformatf("preact[%0d]", n),
                        dut_i.preact[n*`LUT_ADDR_SIZE +: `LUT_ADDR_SIZE], addr);
            check_value($sformatf("outputs[%0d]", n),
                        outputs[n*`LUT_WIDTH +: `LUT_WIDTH], data);
        end
    endtask

    task automatic settle_after_cfg();
        repeat (2) @(negedge clk);                 // a weight change has pulled stable low
        wait_stable_high();
        repeat (`NUM_NEURON + 2) @(negedge clk);   // one lap picks up LUT edits
        check_outputs();
    endtask

    task automatic apply_vector(input logic [`NUM_INPUTS*`IN_WIDTH-1:0] xv);
        logic changed;
        changed = 1'b0;
        for (int n = 0; n < `NUM_NEURON; n++) begin
            if (model_addr(n, xv) != last_addr[n]) begin
                changed = 1'b1;
            end
        end
        @(posedge clk);
        x <= xv;
        if (changed) begin
            wait_stable_low();
        end
        wait_stable_high();
        check_outputs();
    endtask

    task automatic edit_config();
        logic [31:0] r;
        for (int k = 0; k < 3; k++) begin
            write_lut(last_addr[2*k], rand_byte()); // entries in use right now
        end
        r = next_rand();
        write_lut(int'(r[`LUT_ADDR_SIZE-1:0]), rand_byte());
        write_weight(int'(r[20:18]) % `NUM_NEURON, int'(r[17:16]), rand_byte());
        write_weight(6, int'(r[25:24]), rand_byte());
        write_weight(7, int'(r[27:26]), rand_byte());
        end_cfg();
        settle_after_cfg();
    endtask

    task automatic set_all_weights(input logic [7:0] even_w, input logic [7:0] odd_w);
        for (int n = 0; n < `NUM_NEURON; n++) begin
            for (int i = 0; i < `NUM_INPUTS; i++) begin
                write_weight(n, i, (n % 2 == 0) ? even_w : odd_w);
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        x           = '0;
        cfg_we      = 1'b0;
        cfg_addr    = '0;
        cfg_data    = '0;
        lcg_state   = 32'hc74666f4;
        for (int n = 0; n < `NUM_NEURON; n++) begin
            last_addr[n] = -PRE_MIN; // zero weights give the mid address
            for (int i = 0; i < `NUM_INPUTS; i++) begin
                w_model[n][i] = '0;
            end
        end
        for (int a = 0; a < LUT_DEPTH; a++) begin
            lut_model[a] = '0;
        end

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        repeat (4) begin
            @(negedge clk);
            check_value("stable", stable, 0);
            check_value("outputs", outputs, 0);
        end

        // random LUT and weights
        for (int a = 0; a < LUT_DEPTH; a++) begin
            write_lut(a, rand_byte());
        end
        for (int n = 0; n < `NUM_NEURON; n++) begin
            for (int i = 0; i < `NUM_INPUTS; i++) begin
                write_weight(n, i, rand_byte());
            end
        end
        end_cfg();
        settle_after_cfg();

        for (int v = 0; v < NUM_VECTORS; v++) begin
            if (v % 25 == 12) begin
                edit_config();
            end
            apply_vector(next_rand());
        end

        // saturation at both ends of the LUT
        set_all_weights(8'h7f, 8'h80);
        write_lut(0, LOW_END_DATA);
        write_lut(LUT_DEPTH - 1, HIGH_END_DATA);
        end_cfg();
        settle_after_cfg();
        apply_vector({`NUM_INPUTS{8'h7f}});
        check_ends(LUT_DEPTH - 1, 0);
        apply_vector({`NUM_INPUTS{8'h80}});
        check_ends(0, LUT_DEPTH - 1);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/activation_layer_properties.sv
`timescale 1ns/1ns
`default_nettype none

`include "layer_macros.svh"

module activation_layer_properties (
    input wire                                   clk,
    input wire                                   rst,
    input wire [`NUM_NEURON*`LUT_ADDR_SIZE-1:0]  preact,
    input wire                                   stable,
    input wire [$clog2(`NUM_NEURON)-1:0]         count
);

    localparam int SETTLE_CYCLES = `NUM_NEURON + 3;

    logic [4:0] since_rst; // cycles since reset release, saturating

    always_ff @(posedge clk) begin
        if (rst) begin
            since_rst <= '0;
        end else if (since_rst != 5'(SETTLE_CYCLES)) begin
            since_rst <= since_rst + 1'b1;
        end
    end

    // any new pre-activation vector restarts settling
    preact_change_drops_stable: assert property (
        @(posedge clk) disable iff (rst)
        (preact != $past(preact)) |=> !stable
    ) else $error("stable still high one cycle after a pre-activation change");

    stable_low_after_reset: assert property (
        @(posedge clk) disable iff (rst)
        (since_rst < 5'(SETTLE_CYCLES)) |-> !stable
    ) else $error("stable rose too soon after reset");

    count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        count < `NUM_NEURON
    ) else $error("round-robin counter left the neuron range");

endmodule

`default_nettype wire

// File: rtl/activation_layer.sv
`timescale 1ns/1ns
`default_nettype none

`include "layer_macros.svh"

module activation_layer (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire  [`NUM_INPUTS*`IN_WIDTH-1:0]           x,
    input  wire                                        cfg_we,
    input  layer_pkg::cfg_addr_t                       cfg_addr,
    input  wire  [7:0]                                 cfg_data,
    output logic [`NUM_NEURON*`LUT_WIDTH-1:0]          outputs,
    output logic                                       stable
);

    logic [`NUM_NEURON*`LUT_ADDR_SIZE-1:0] preact;
    logic [`LUT_ADDR_SIZE-1:0]             rd_addr;
    logic [`LUT_WIDTH-1:0]                 rd_data;

    // dot products, scaling and address forming
    neuron_sum sum_i (
        .clk      (clk),
        .rst      (rst),
        .x        (x),
        .cfg_we   (cfg_we),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .preact   (preact)
    );

    // round-robin lookup of all six neurons
    activation act_i (
        .clk     (clk),
        .rst     (rst),
        .preact  (preact),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .outputs (outputs),
        .stable  (stable)
    );

    lut_bram lut_i (
        .clk      (clk),
        .cfg_we   (cfg_we),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

// File: rtl/activation.sv
`timescale 1ns/1ns
`default_nettype none

`include "layer_macros.svh"

module activation (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire  [`NUM_NEURON*`LUT_ADDR_SIZE-1:0]      preact,
    output logic [`LUT_ADDR_SIZE-1:0]                  rd_addr,
    input  wire  [`LUT_WIDTH-1:0]                      rd_data,
    output logic [`NUM_NEURON*`LUT_WIDTH-1:0]          outputs,
    output logic                                       stable
);

    localparam int CNT_WIDTH    = $clog2(`NUM_NEURON);
    localparam int SETTLE_MAX   = `NUM_NEURON + 3;  // one full lap plus pipeline slack
    localparam int SETTLE_WIDTH = $clog2(SETTLE_MAX + 1);

    logic [CNT_WIDTH-1:0]                    count;
    logic [CNT_WIDTH-1:0]                    count_d1;  // neuron whose address is in rd_addr
    logic [CNT_WIDTH-1:0]                    count_d2;  // neuron whose value is on rd_data
    logic [`NUM_NEURON*`LUT_ADDR_SIZE-1:0]   preact_prev;
    logic [SETTLE_WIDTH-1:0]                 settle_cnt;
    logic                                    preact_same;

    assign preact_same = (preact == preact_prev);

    always_ff @(posedge clk) begin
        if (rst) begin
            count    <= '0;
            count_d1 <= '0;
            count_d2 <= '0;
        end else begin
            if (count == CNT_WIDTH'(`NUM_NEURON - 1)) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            count_d1 <= count;
            count_d2 <= count_d1;
        end
    end

    // RAM address for the neuron whose turn it is
    always_ff @(posedge clk) begin
        rd_addr <= preact[count*`LUT_ADDR_SIZE +: `LUT_ADDR_SIZE];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outputs <= '0;
        end else begin
            outputs[count_d2*`LUT_WIDTH +: `LUT_WIDTH] <= rd_data;
        end
    end

    // settle tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            preact_prev <= '0;
            settle_cnt  <= '0;
        end else begin
            preact_prev <= preact;
            if (!preact_same) begin
                settle_cnt <= '0;             // restart on any change
            end else if (settle_cnt != SETTLE_WIDTH'(SETTLE_MAX)) begin
                settle_cnt <= settle_cnt + 1'b1;
            end
        end
    end

    assign stable = (settle_cnt == SETTLE_WIDTH'(SETTLE_MAX));

endmodule

`default_nettype wire

// File: rtl/neuron_sum.sv
`timescale 1ns/1ns
`default_nettype none

`include "layer_macros.svh"

module neuron_sum (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire  [`NUM_INPUTS*`IN_WIDTH-1:0]           x,
    input  wire                                        cfg_we,
    input  layer_pkg::cfg_addr_t                       cfg_addr,
    input  wire  [`W_WIDTH-1:0]                        cfg_data,
    output logic [`NUM_NEURON*`LUT_ADDR_SIZE-1:0]      preact
);

    localparam int PROD_WIDTH = `IN_WIDTH + `W_WIDTH;
    localparam int SUM_WIDTH  = PROD_WIDTH + $clog2(`NUM_INPUTS); // room for the carries
    localparam int PRE_MAX    = (1 << (`LUT_ADDR_SIZE - 1)) - 1;
    localparam int PRE_MIN    = -(1 << (`LUT_ADDR_SIZE - 1));

    logic signed [`W_WIDTH-1:0]        weights [`NUM_NEURON][`NUM_INPUTS];
    logic signed [`IN_WIDTH-1:0]       x_in    [`NUM_INPUTS];
    logic signed [SUM_WIDTH-1:0]       raw_sum [`NUM_NEURON];
    logic signed [SUM_WIDTH-1:0]       scaled  [`NUM_NEURON];
    logic signed [`LUT_ADDR_SIZE-1:0]  clamped [`NUM_NEURON];
    logic [`NUM_NEURON*`LUT_ADDR_SIZE-1:0] addr_next;
    logic                              weight_we;

    // neuron indices past the last neuron fall on the floor
    assign weight_we = cfg_we && !cfg_addr.weight.sel &&
                       (cfg_addr.weight.neuron < `NUM_NEURON);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < `NUM_NEURON; n++) begin
                for (int i = 0; i < `NUM_INPUTS; i++) begin
                    weights[n][i] <= '0;
                end
            end
        end else if (weight_we) begin
            weights[cfg_addr.weight.neuron][cfg_addr.weight.input_idx] <= cfg_data;
        end
    end

    // input 0 sits in the low bits
    always_comb begin
        for (int i = 0; i < `NUM_INPUTS; i++) begin
            x_in[i] = x[i*`IN_WIDTH +: `IN_WIDTH];
        end
    end

    always_comb begin
        for (int n = 0; n < `NUM_NEURON; n++) begin
            raw_sum[n] = '0;
            for (int i = 0; i < `NUM_INPUTS; i++) begin
                raw_sum[n] = raw_sum[n] + x_in[i] * weights[n][i];
            end

            scaled[n] = raw_sum[n] >>> `SUM_SHIFT;

            // saturate to the signed pre-activation range
            if (scaled[n] > PRE_MAX) begin
                clamped[n] = {1'b0, {(`LUT_ADDR_SIZE-1){1'b1}}};
            end else if (scaled[n] < PRE_MIN) begin
                clamped[n] = {1'b1, {(`LUT_ADDR_SIZE-1){1'b0}}};
            end else begin
                clamped[n] = scaled[n][`LUT_ADDR_SIZE-1:0];
            end

            // +512 offset is just a flipped sign bit
            addr_next[n*`LUT_ADDR_SIZE +: `LUT_ADDR_SIZE] =
                {~clamped[n][`LUT_ADDR_SIZE-1], clamped[n][`LUT_ADDR_SIZE-2:0]};
        end
    end

    always_ff @(posedge clk) begin
        preact <= addr_next;
    end

endmodule

`default_nettype wire

// File: rtl/lut_bram.sv
`timescale 1ns/1ns
`default_nettype none

`include "layer_macros.svh"

module lut_bram (
    input  wire                        clk,
    input  wire                        cfg_we,
    input  layer_pkg::cfg_addr_t       cfg_addr,
    input  wire [`LUT_WIDTH-1:0]       cfg_data,
    input  wire [`LUT_ADDR_SIZE-1:0]   rd_addr,
    output logic [`LUT_WIDTH-1:0]      rd_data
);

    localparam int LUT_DEPTH = 1 << `LUT_ADDR_SIZE;

    logic [`LUT_WIDTH-1:0] mem [LUT_DEPTH];
    logic                  lut_we;

    // only the LUT reading of the config word lands here
    assign lut_we = cfg_we && cfg_addr.lut.sel;

    initial begin
        for (int i = 0; i < LUT_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (lut_we) begin
            mem[cfg_addr.lut.lut_addr] <= cfg_data;
        end
        rd_data <= mem[rd_addr]; // read-first on a collision
    end

endmodule

`default_nettype wire

// File: rtl/layer_pkg.sv
`default_nettype none

`include "layer_macros.svh"

package layer_pkg;

    // one configuration address, two readings selected by the top bit
    typedef union packed {
        struct packed {
            logic                          sel;        // 1 selects the LUT
            logic [`LUT_ADDR_SIZE-1:0]     lut_addr;
        } lut;
        struct packed {
            logic                          sel;        // 0 selects a weight
            logic [`CFG_ADDR_SIZE-1-`NEURON_IDX_SIZE-`INPUT_IDX_SIZE-1:0] pad;
            logic [`NEURON_IDX_SIZE-1:0]   neuron;
            logic [`INPUT_IDX_SIZE-1:0]    input_idx;
        } weight;
    } cfg_addr_t;

endpackage

`default_nettype wire

// File: rtl/layer_macros.svh
`ifndef LAYER_MACROS_SVH
`define LAYER_MACROS_SVH

// layer geometry
`define NUM_NEURON      6
`define NUM_INPUTS      4

// operand widths, all signed
`define IN_WIDTH        8
`define W_WIDTH         8

// pre-activation doubles as the LUT address
`define LUT_ADDR_SIZE   10
`define LUT_WIDTH       8
`define SUM_SHIFT       6   // raw sum >>> this before clamping

// configuration port
`define CFG_ADDR_SIZE   11
`define NEURON_IDX_SIZE 3
`define INPUT_IDX_SIZE  2

`endif
